/* rv32i_types.sv */
// isa view shared by the fetch side and the predictor
package rv32i_types;

    // pc, immediate and target all travel as one plain word
    typedef logic [31:0] rv32i_word;

    // major opcodes, bits 6:0 of the instruction word
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111, // load upper immediate
        op_auipc = 7'b0010111, // add upper immediate to pc
        op_jal   = 7'b1101111, // jump and link, pc relative
        op_jalr  = 7'b1100111, // jump and link register, target from rs1
        op_br    = 7'b1100011, // conditional branch
        op_load  = 7'b0000011, // loads
        op_store = 7'b0100011, // stores
        op_imm   = 7'b0010011, // alu with immediate
        op_reg   = 7'b0110011, // alu register register
        op_csr   = 7'b1110011  // csr and system
    } rv32i_opcode;

    // only op_br, op_jal and op_jalr steer the fetch
    // every other value falls through to pc plus 4,
    // including words that match none of the above

endpackage : rv32i_types

/* bp_types.sv */
// predictor view, direction counters of the gshare table
package bp_types;

    // two bit saturating counter
    // the encoding is ordered so that counting up means "more taken"
    // and the upper bit alone gives the direction
    typedef enum logic [1:0] {
        strong_not_taken = 2'b00, // saturated low
        weak_not_taken   = 2'b01, // one taken away from flipping
        weak_taken       = 2'b10, // one not taken away from flipping
        strong_taken     = 2'b11  // saturated high
    } counter_state;

    // every table entry starts here after reset
    // so one taken outcome is enough to flip an untrained entry
    parameter counter_state counter_reset_state = weak_not_taken;

    // transitions, for reference
    //   taken     : snt -> wnt -> wt -> st -> st
    //   not taken : st -> wt -> wnt -> snt -> snt

endpackage : bp_types

/* insn_predecode.sv */
`timescale 1ns/100ps

module insn_predecode
import rv32i_types::*;
(
    input  rv32i_word   ir,            // fetched word at predict_pc
    input  rv32i_word   predict_pc,    // pc in fetch
    output rv32i_opcode opcode,
    output rv32i_word   branch_target, // pc + b immediate
    output rv32i_word   jal_target,    // pc + j immediate
    output rv32i_word   seq_pc         // pc + 4
);

    rv32i_word b_imm;
    rv32i_word j_imm;

    // opcode straight off the low bits of the word
    assign opcode = rv32i_opcode'(ir[6:0]);

    // b type keeps imm[12|10:5] in 31:25 and imm[4:1|11] in 11:7
    assign b_imm = {{20{ir[31]}},  // sign
                    ir[7],         // imm[11]
                    ir[30:25],     // imm[10:5]
                    ir[11:8],      // imm[4:1]
                    1'b0};         // always even

    // j type keeps imm[20|10:1|11|19:12] in 31:12
    assign j_imm = {{12{ir[31]}},  // sign
                    ir[19:12],     // imm[19:12]
                    ir[20],        // imm[11]
                    ir[30:21],     // imm[10:1]
                    1'b0};

    // targets formed for every word and picked in next_pc_select
    assign branch_target = predict_pc + b_imm;
    assign jal_target    = predict_pc + j_imm;
    assign seq_pc        = predict_pc + 32'd4; // no compressed support

    // fetch only ever asks for aligned words
    always_comb begin
        if (!$isunknown(predict_pc)) begin
            assert (predict_pc[1:0] == 2'b00)
                else $error("predict_pc %h not word aligned", predict_pc);
        end
    end

endmodule : insn_predecode

/* pattern_history_table.sv */
`timescale 1ns/100ps

module pattern_history_table
import rv32i_types::*, bp_types::*;
#(
    parameter int pht_index_bits = 6, // 2**pht_index_bits counters
    parameter int history_bits   = 6  // global history length
)
(
    input  logic      clk,
    input  logic      reset,
    input  rv32i_word predict_pc,    // fetch side lookup
    input  rv32i_word update_pc,     // pc of the resolved branch
    input  logic      update_valid,  // one cycle strobe from execute
    input  logic      actual_taken,  // resolved outcome
    output logic      predict_taken
);

    localparam int pht_entries = 1 << pht_index_bits;

    typedef logic [pht_index_bits-1:0] pht_index_t;
    typedef logic [history_bits-1:0]   history_t;

    counter_state counters [pht_entries];
    history_t     history;        // newest outcome in bit 0
    pht_index_t   predict_index;
    pht_index_t   update_index;
    counter_state predict_entry;
    counter_state update_entry;
    counter_state update_next;

    // history sits in the low index bits, so it can never be wider
    if (history_bits > pht_index_bits) begin : g_history_check
        $error("history_bits %0d exceeds pht_index_bits %0d",
               history_bits, pht_index_bits);
    end

    // gshare index, word pc bits xor history
    // both sides see the same history, update uses it before the shift
    assign predict_index = predict_pc[pht_index_bits+1:2] ^ pht_index_t'(history);
    assign update_index  = update_pc[pht_index_bits+1:2] ^ pht_index_t'(history);

    assign predict_entry = counters[predict_index];
    assign predict_taken = predict_entry[1]; // upper bit is the direction

    // saturating step of the entry being trained
    assign update_entry = counters[update_index];

    always_comb begin
        case (update_entry)
            strong_not_taken: update_next = actual_taken ? weak_not_taken : strong_not_taken;
            weak_not_taken:   update_next = actual_taken ? weak_taken     : strong_not_taken;
            weak_taken:       update_next = actual_taken ? strong_taken   : weak_not_taken;
            strong_taken:     update_next = actual_taken ? strong_taken   : weak_taken;
            default:          update_next = counter_reset_state; // x recovery
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            history <= '0;
            for (int i = 0; i < pht_entries; i++) begin
                counters[i] <= counter_reset_state;
            end
        end else if (update_valid) begin
            counters[update_index] <= update_next;
            // shift left, outcome enters at the bottom, oldest drops off
            history <= history_t'({history, actual_taken});
        end
    end

    // an x in the history would smear over every lookup index
    history_known_a: assert property (
        @(posedge clk) disable iff (reset) !$isunknown(history)
    ) else $error("global history has unknown bits");

endmodule : pattern_history_table

/* branch_target_buffer.sv */
`timescale 1ns/100ps

module branch_target_buffer
import rv32i_types::*;
#(
    parameter int btb_index_bits = 4 // 2**btb_index_bits sets
)
(
    input  logic      clk,
    input  logic      reset,
    input  rv32i_word predict_pc,  // fetch side lookup
    input  rv32i_word update_pc,   // pc of the resolved jalr
    input  logic      write_valid, // one cycle strobe from execute
    input  rv32i_word target_pc,   // resolved jalr target
    output rv32i_word hit_target,
    output logic      hit
);

    localparam int btb_sets = 1 << btb_index_bits;
    localparam int tag_bits = 30 - btb_index_bits; // pc bits above the index

    typedef logic [btb_index_bits-1:0] btb_index_t;
    typedef logic [tag_bits-1:0]       btb_tag_t;

    logic [btb_sets-1:0] valid_bits;
    btb_tag_t            tags    [btb_sets];
    rv32i_word           targets [btb_sets];

    btb_index_t read_index;
    btb_tag_t   read_tag;
    btb_index_t write_index;
    btb_tag_t   write_tag;

    // direct mapped with the index just above the byte offset
    assign read_index  = predict_pc[btb_index_bits+1:2];
    assign read_tag    = predict_pc[31:btb_index_bits+2];
    assign write_index = update_pc[btb_index_bits+1:2];
    assign write_tag   = update_pc[31:btb_index_bits+2];

    // one valid bit per set, raised by the first jalr write
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_bits <= '0;
        end else if (write_valid) begin
            valid_bits[write_index] <= 1'b1;
        end
    end

    // a new jalr simply replaces the tag and target of its set
    always_ff @(posedge clk) begin
        if (write_valid) begin
            tags[write_index]    <= write_tag;
            targets[write_index] <= target_pc;
        end
    end

    // combinational read in the fetch cycle
    assign hit        = valid_bits[read_index] && (tags[read_index] == read_tag);
    assign hit_target = targets[read_index]; // only meaningful with hit

    // execute should never hand back a misaligned jalr target
    target_aligned_a: assert property (
        @(posedge clk) disable iff (reset)
        write_valid |-> (target_pc[1:0] == 2'b00)
    ) else $error("jalr target %h not word aligned", target_pc);

endmodule : branch_target_buffer

/* next_pc_select.sv */
`timescale 1ns/100ps

module next_pc_select
import rv32i_types::*;
(
    input  rv32i_opcode opcode,        // from predecode
    input  logic        predict_taken, // gshare direction
    input  rv32i_word   branch_target,
    input  rv32i_word   jal_target,
    input  rv32i_word   hit_target,    // btb target
    input  rv32i_word   seq_pc,
    input  logic        hit,           // btb lookup hit
    output rv32i_word   predicted_pc
);

    // class policy lives only here
    always_comb begin
        if ((opcode == op_br) && predict_taken) begin
            predicted_pc = branch_target;   // predicted taken branch
        end else if (opcode == op_jal) begin
            predicted_pc = jal_target;      // always taken, target known
        end else if ((opcode == op_jalr) && hit) begin
            predicted_pc = hit_target;      // remembered register target
        end else begin
            // not taken branch, btb miss, or no control flow at all
            predicted_pc = seq_pc;
        end
    end

endmodule : next_pc_select

/* branch_predictor.sv */
`timescale 1ns/100ps

module branch_predictor
import rv32i_types::*;
#(
    parameter int pht_index_bits = 6,
    parameter int history_bits   = 6, // must not exceed pht_index_bits
    parameter int btb_index_bits = 4
)
(
    input  logic      clk,
    input  logic      reset,
    input  rv32i_word predict_pc,   // fetch pc
    input  rv32i_word ir,           // word fetched at predict_pc
    input  rv32i_word update_pc,    // pc of the instruction resolved in execute
    input  logic      branch_valid, // resolved conditional branch
    input  logic      branch_taken,
    input  logic      jump_valid,   // resolved jalr
    input  rv32i_word target_pc,    // jalr target
    output rv32i_word predicted_pc
);

    rv32i_opcode opcode;
    rv32i_word   branch_target;
    rv32i_word   jal_target;
    rv32i_word   seq_pc;
    logic        predict_taken;
    rv32i_word   hit_target;
    logic        hit;

    insn_predecode u_predecode (
        .ir            (ir),
        .predict_pc    (predict_pc),
        .opcode        (opcode),
        .branch_target (branch_target),
        .jal_target    (jal_target),
        .seq_pc        (seq_pc)
    );

    // direction for conditional branches
    pattern_history_table #(
        .pht_index_bits (pht_index_bits),
        .history_bits   (history_bits)
    ) u_pht (
        .clk           (clk),
        .reset         (reset),
        .predict_pc    (predict_pc),
        .update_pc     (update_pc),
        .update_valid  (branch_valid),
        .actual_taken  (branch_taken),
        .predict_taken (predict_taken)
    );

    // targets for jalr only, jal is resolved by predecode
    branch_target_buffer #(
        .btb_index_bits (btb_index_bits)
    ) u_btb (
        .clk         (clk),
        .reset       (reset),
        .predict_pc  (predict_pc),
        .update_pc   (update_pc),
        .write_valid (jump_valid),
        .target_pc   (target_pc),
        .hit_target  (hit_target),
        .hit         (hit)
    );

    next_pc_select u_select (
        .opcode        (opcode),
        .predict_taken (predict_taken),
        .branch_target (branch_target),
        .jal_target    (jal_target),
        .hit_target    (hit_target),
        .seq_pc        (seq_pc),
        .hit           (hit),
        .predicted_pc  (predicted_pc)
    );

    // execute resolves one instruction per cycle, so the two strobes exclude
    update_onehot_a: assert property (
        @(posedge clk) disable iff (reset) !(branch_valid && jump_valid)
    ) else $error("branch_valid and jump_valid high together");

endmodule : branch_predictor

/* tb_branch_predictor.sv */
`timescale 1ns/100ps

module tb_branch_predictor
import rv32i_types::*, bp_types::*;
();

    localparam int pht_bits    = 6; // dut defaults
    localparam int hist_bits   = 6;
    localparam int btb_bits    = 4;
    localparam int pht_entries = 1 << pht_bits;
    localparam int btb_sets    = 1 << btb_bits;
    localparam int n_idle      = 40;
    localparam int n_alias     = 24;
    localparam int n_random    = 2000;
    localparam int total_steps = 2 + n_idle + 9 + n_alias + 5 + n_random;

    logic      clk;
    logic      reset;
    rv32i_word predict_pc;
    rv32i_word ir;
    rv32i_word update_pc;
    logic      branch_valid;
    logic      branch_taken;
    logic      jump_valid;
    rv32i_word target_pc;
    rv32i_word predicted_pc;

    // reference model state
    logic [hist_bits-1:0]   model_history;
    counter_state           model_counters [pht_entries];
    logic                   model_valid    [btb_sets];
    logic [31:btb_bits+2]   model_tags     [btb_sets];
    rv32i_word              model_targets  [btb_sets];

    logic [31:0] rng_state;
    rv32i_word   pc_pool [8]; // small pool so entries alias
    int          checks;
    int          errors;

    branch_predictor dut (
        .clk          (clk),
        .reset        (reset),
        .predict_pc   (predict_pc),
        .ir           (ir),
        .update_pc    (update_pc),
        .branch_valid (branch_valid),
        .branch_taken (branch_taken),
        .jump_valid   (jump_valid),
        .target_pc    (target_pc),
        .predicted_pc (predicted_pc)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk; // 100 ns period

    // xorshift32
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // class 0 br, 1 jal, 2 jalr, else something that is no control flow
    function automatic rv32i_word make_word(input int cls);
        rv32i_word   r;
        rv32i_opcode op;
        r = next_rand();
        if (cls == 0) return {r[31:7], op_br};
        if (cls == 1) return {r[31:7], op_jal};
        if (cls == 2) return {r[31:7], op_jalr};
        case (r[2:0])
            3'd0:    op = op_lui;
            3'd1:    op = op_auipc;
            3'd2:    op = op_load;
            3'd3:    op = op_store;
            3'd4:    op = op_imm;
            3'd5:    op = op_reg;
            3'd6:    op = op_csr;
            default: return {r[31:7], 7'b0001111}; // fence, not in the enum
        endcase
        return {r[31:7], op};
    endfunction

    // next pc straight from the isa encodings and the model tables
    function automatic rv32i_word expected_next(input rv32i_word pc, input rv32i_word word);
        logic signed [12:0]  b_imm;
        logic signed [20:0]  j_imm;
        logic [pht_bits-1:0] slot;
        logic [btb_bits-1:0] set;
        b_imm = {word[31], word[7], word[30:25], word[11:8], 1'b0};
        j_imm = {word[31], word[19:12], word[20], word[30:21], 1'b0};
        slot  = pc[pht_bits+1:2] ^ model_history;
        set   = pc[btb_bits+1:2];
        if (word[6:0] == op_br && model_counters[slot][1]) begin
            return pc + 32'(b_imm);
        end
        if (word[6:0] == op_jal) return pc + 32'(j_imm);
        if (word[6:0] == op_jalr && model_valid[set] && model_tags[set] == pc[31:btb_bits+2]) begin
            return model_targets[set];
        end
        return pc + 32'd4;
    endfunction

    task automatic model_reset();
        model_history = '0;
        for (int i = 0; i < pht_entries; i++) model_counters[i] = counter_reset_state;
        for (int i = 0; i < btb_sets; i++) begin
            model_valid[i]   = 1'b0;
            model_tags[i]    = '0;
            model_targets[i] = '0;
        end
    endtask

    // consume the strobes of the cycle that just ended
    task automatic model_update();
        logic [pht_bits-1:0] slot;
        logic [btb_bits-1:0] set;
        counter_state        c;
        if (branch_valid) begin
            slot = update_pc[pht_bits+1:2] ^ model_history; // history before the shift
            c = model_counters[slot];
            if (branch_taken && c != strong_taken) c = counter_state'(c + 2'd1);
            else if (!branch_taken && c != strong_not_taken) c = counter_state'(c - 2'd1);
            model_counters[slot] = c;
            model_history = {model_history[hist_bits-2:0], branch_taken};
        end
        if (jump_valid) begin
            set = update_pc[btb_bits+1:2];
            model_valid[set]   = 1'b1;
            model_tags[set]    = update_pc[31:btb_bits+2];
            model_targets[set] = target_pc;
        end
    endtask

    task automatic check_value(input rv32i_word expected, input rv32i_word actual,
                               input string name);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
        end
    endtask

    task automatic advance();
        @(posedge clk);
        model_update();
    endtask

    task automatic apply_and_check(input rv32i_word pc, input rv32i_word word,
                                   input logic bv, input logic bt, input logic jv,
                                   input rv32i_word upc, input rv32i_word tgt);
        predict_pc   <= pc;
        ir           <= word;
        update_pc    <= upc;
        branch_valid <= bv;
        branch_taken <= bt;
        jump_valid   <= jv;
        target_pc    <= tgt;
        @(negedge clk); // combinational output settled
        check_value(expected_next(pc, word), predicted_pc, "predicted_pc");
    endtask

    task automatic step(input rv32i_word pc, input rv32i_word word, input logic bv,
                        input logic bt, input logic jv, input rv32i_word upc,
                        input rv32i_word tgt);
        advance();
        apply_and_check(pc, word, bv, bt, jv, upc, tgt);
    endtask

    // walk one table entry up to saturation and back down
    // pc chosen each cycle so pc xor history lands on the same entry
    task automatic train_sequence(input logic [pht_bits-1:0] entry);
        logic [8:0] dir_before; // direction seen before each update, last one after
        rv32i_word  pc;
        rv32i_word  word;
        word       = {7'b0, 5'd2, 5'd1, 3'b000, 4'b1000, 1'b0, op_br}; // beq, offset +16
        dir_before = 9'b0_0011_1110;
        for (int i = 0; i < 9; i++) begin
            advance();
            pc = {20'h000, 4'h2, entry ^ model_history, 2'b00};
            apply_and_check(pc, word, i < 8, i < 4, 1'b0, pc, 32'h0);
            check_value(dir_before[i] ? pc + 32'd16 : pc + 32'd4, predicted_pc, "predicted_pc");
        end
    endtask

    // hang guard, sized from the step count
    initial begin
        #((total_steps + 100) * 100);
        $display("timeout: run did not finish within %0d cycles", total_steps + 100);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        rv32i_word r;
        rv32i_word a;
        rv32i_word b;
        rv32i_word t1;
        rv32i_word t2;
        rv32i_word jw;
        checks       = 0;
        errors       = 0;
        rng_state    = 32'h3db1_944f;
        reset        <= 1'b1;
        predict_pc   <= '0;
        ir           <= '0;
        update_pc    <= '0;
        branch_valid <= 1'b0;
        branch_taken <= 1'b0;
        jump_valid   <= 1'b0;
        target_pc    <= '0;
        model_reset();
        for (int i = 0; i < 4; i++) begin
            r = next_rand();
            pc_pool[i]     = r & 32'h0000_0ffc;
            pc_pool[i + 4] = pc_pool[i] ^ 32'h0000_1000; // same indexes, other tag
        end
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // untrained predictor, only jal leaves the sequential path
        for (int i = 0; i < n_idle; i++) begin
            r = next_rand();
            step(pc_pool[r[2:0]], make_word(int'(r[4:3])), 1'b0, 1'b0, 1'b0, '0, '0);
        end

        train_sequence(6'h15);

        // one pc under a moving history
        for (int i = 0; i < n_alias; i++) begin
            r = next_rand();
            step(pc_pool[1], make_word(0), 1'b1, r[0], 1'b0, pc_pool[r[3:1]], '0);
        end

        // btb fill, hit, conflict and overwrite
        a  = pc_pool[0];
        b  = a ^ 32'h0000_1000;
        t1 = next_rand() & 32'hffff_fffc;
        t2 = next_rand() & 32'hffff_fffc;
        jw = make_word(2);
        step(a, jw, 1'b0, 1'b0, 1'b1, a, t1);
        check_value(a + 32'd4, predicted_pc, "predicted_pc"); // still empty
        step(a, jw, 1'b0, 1'b0, 1'b0, '0, '0);
        check_value(t1, predicted_pc, "predicted_pc");
        step(b, jw, 1'b0, 1'b0, 1'b1, b, t2);
        check_value(b + 32'd4, predicted_pc, "predicted_pc"); // tag differs
        step(a, jw, 1'b0, 1'b0, 1'b0, '0, '0);
        check_value(a + 32'd4, predicted_pc, "predicted_pc"); // evicted by b
        step(b, jw, 1'b0, 1'b0, 1'b0, '0, '0);
        check_value(t2, predicted_pc, "predicted_pc");

        // long random mix, at most one strobe per cycle
        for (int i = 0; i < n_random; i++) begin
            r = next_rand();
            step(pc_pool[r[2:0]], make_word(int'(r[4:3])),
                 r[9:8] == 2'd1, r[10], r[9:8] == 2'd2, pc_pool[r[7:5]],
                 next_rand() & 32'hffff_fffc);
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_branch_predictor

/* flist.f */
rv32i_types.sv
bp_types.sv
insn_predecode.sv
pattern_history_table.sv
branch_target_buffer.sv
next_pc_select.sv
branch_predictor.sv
tb_branch_predictor.sv

/* Makefile */
TOP = tb_branch_predictor

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator from flist.f and run the testbench"
	@echo "  clean  remove obj_dir"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o sim_$(TOP)
	@out=$$(./obj_dir/sim_$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
